// ==== design/i2c_bit_engine.sv ====
`timescale 1ns/1ps
`include "i2c_master_defines.svh"

module i2c_bit_engine import i2c_master_pkg::*; (
	input  logic       i_clock,
	input  logic       i_rst_n,
	input  logic       i_bit_req,
	input  bit_op_e    i_bit_op,
	input  logic [7:0] i_tx_byte,
	input  logic       i_sda_in,
	output logic       o_bit_ack,
	output logic [7:0] o_rx_byte,
	output logic       o_bit_nack,
	output logic       o_scl,
	output logic       o_sda_oe,
	output logic       o_sda_out
);
	localparam int TW = $clog2(`I2C_HALF_PERIOD);

	typedef enum logic [2:0] {
		ENG_IDLE,
		ENG_START,
		ENG_STOP,
		ENG_BIT_LOW,
		ENG_BIT_HIGH,
		ENG_DONE
	} eng_state_e;

	eng_state_e    state;
	bit_op_e       op_q;
	logic [TW-1:0] timer;
	logic [1:0]    step;
	logic [3:0]    bit_cnt;	// 8 is the acknowledge slot
	logic [7:0]    shift;

	// Wire changes happen on the first clock of a phase
	wire phase_entry = (timer == '0);
	wire phase_end = (timer == TW'(`I2C_HALF_PERIOD - 1));
	wire is_write = (op_q == OP_WRITE_BYTE);

	assign o_rx_byte = shift;

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state <= ENG_IDLE;
			timer <= '0;
			step <= '0;
			bit_cnt <= '0;
			o_bit_ack <= 1'b0;
			o_bit_nack <= 1'b0;
			o_scl <= 1'b1;
			o_sda_oe <= 1'b0;
			o_sda_out <= 1'b1;
		end else begin
			timer <= phase_end ? '0 : timer + 1'b1;
			case (state)
				ENG_IDLE: begin
					timer <= '0;
					if (i_bit_req) begin
						op_q <= i_bit_op;
						shift <= i_tx_byte;
						step <= '0;
						bit_cnt <= '0;
						o_bit_nack <= 1'b0;
						case (i_bit_op)
							OP_START: state <= ENG_START;
							OP_STOP:  state <= ENG_STOP;
							default:  state <= ENG_BIT_LOW;
						endcase
					end
				end
				ENG_START: begin
					if (phase_entry) begin
						case (step)
							2'd0: o_sda_oe <= 1'b0;	// Release first for repeated start
							2'd1: o_scl <= 1'b1;
							2'd2: begin
								o_sda_oe <= 1'b1;
								o_sda_out <= 1'b0;
							end
							default: o_scl <= 1'b0;
						endcase
					end
					if (phase_end) begin
						step <= step + 1'b1;
						if (step == 2'd3) begin
							o_bit_ack <= 1'b1;
							state <= ENG_DONE;
						end
					end
				end
				ENG_STOP: begin
					if (phase_entry) begin
						case (step)
							2'd0: begin
								o_sda_oe <= 1'b1;
								o_sda_out <= 1'b0;
							end
							2'd1: o_scl <= 1'b1;
							default: o_sda_oe <= 1'b0;	// SDA rises with SCL high
						endcase
					end
					if (phase_end) begin
						step <= step + 1'b1;
						if (step == 2'd2) begin
							o_bit_ack <= 1'b1;
							state <= ENG_DONE;
						end
					end
				end
				ENG_BIT_LOW: begin
					if (phase_entry) begin
						if (bit_cnt == 4'd8) begin
							o_sda_oe <= !is_write;
							o_sda_out <= (op_q == OP_READ_NACK);
						end else begin
							o_sda_oe <= is_write;
							o_sda_out <= shift[7];
						end
					end
					if (phase_end)
						state <= ENG_BIT_HIGH;
				end
				ENG_BIT_HIGH: begin
					if (phase_entry)
						o_scl <= 1'b1;
					if (phase_end) begin
						o_scl <= 1'b0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 4'd8) begin
							o_bit_nack <= is_write && i_sda_in;
							o_bit_ack <= 1'b1;
							state <= ENG_DONE;
						end else begin
							shift <= {shift[6:0], i_sda_in};	// Sampled at the end of SCL high
							state <= ENG_BIT_LOW;
						end
					end
				end
				default: begin
					timer <= '0;
					if (!i_bit_req) begin
						o_bit_ack <= 1'b0;
						state <= ENG_IDLE;
					end
				end
			endcase
		end
	end

endmodule

// ==== design/i2c_host_regs.sv ====
`timescale 1ns/1ps
`include "i2c_master_defines.svh"

module i2c_host_regs (
	input  logic        i_clock,
	input  logic        i_rst_n,
	input  logic        i_req,
	input  logic        i_we,
	input  logic [1:0]  i_addr,
	input  logic [31:0] i_wdata,
	input  logic        i_cmd_full,
	input  logic        i_cmd_empty,
	input  logic        i_rx_full,
	input  logic        i_rx_empty,
	input  logic [7:0]  i_rx_data,
	input  logic        i_busy,
	input  logic        i_nack,
	output logic [31:0] o_rdata,
	output logic        o_ack,
	output logic        o_cmd_push,
	output logic [31:0] o_cmd_word,
	output logic        o_rx_pop
);
	logic [31:0] status;

	assign status = {26'b0, i_nack, i_busy, i_cmd_empty, i_cmd_full, i_rx_empty, i_rx_full};

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_ack <= 1'b0;
			o_cmd_push <= 1'b0;
			o_rx_pop <= 1'b0;
		end else begin
			o_cmd_push <= 1'b0;
			o_rx_pop <= 1'b0;
			if (i_req && !o_ack) begin
				if (i_we && i_addr == `I2C_REG_CTRL) begin
					if (!i_cmd_full) begin	// Host waits here while the queue is full
						o_cmd_word <= i_wdata;
						o_cmd_push <= 1'b1;
						o_ack <= 1'b1;
					end
				end else if (!i_we && i_addr == `I2C_REG_CTRL) begin
					o_rdata <= status;
					o_ack <= 1'b1;
				end else if (!i_we && i_addr == `I2C_REG_RXDATA) begin
					if (!i_rx_empty) begin
						if (!o_rx_pop)
							o_rx_pop <= 1'b1;
						else begin
							o_rdata <= {24'b0, i_rx_data};	// Head still valid on the pop edge
							o_ack <= 1'b1;
						end
					end
				end else begin
					o_rdata <= 32'b0;
					o_ack <= 1'b1;
				end
			end else if (!i_req)
				o_ack <= 1'b0;
		end
	end

endmodule

// ==== design/i2c_master_defines.svh ====
`ifndef I2C_MASTER_DEFINES_SVH
`define I2C_MASTER_DEFINES_SVH

`define I2C_FIFO_DEPTH  16
`define I2C_HALF_PERIOD 8	// Clocks per SCL phase

// Host register map
`define I2C_REG_CTRL    2'd0
`define I2C_REG_RXDATA  2'd1

`endif

// ==== design/i2c_master_pkg.sv ====
package i2c_master_pkg;

	typedef enum logic [1:0] {
		CMD_NONE  = 2'd0,
		CMD_READ  = 2'd1,
		CMD_WRITE = 2'd2
	} i2c_cmd_e;

	typedef enum logic [2:0] {
		OP_START,
		OP_STOP,
		OP_WRITE_BYTE,
		OP_READ_ACK,
		OP_READ_NACK
	} bit_op_e;

	// One state per bus step
	typedef enum logic [3:0] {
		SEQ_IDLE, SEQ_START, SEQ_ADDR_W, SEQ_REG, SEQ_DATA,
		SEQ_RESTART, SEQ_ADDR_R, SEQ_READ, SEQ_PUSH, SEQ_STOP
	} seq_state_e;

endpackage

// ==== design/i2c_master_top.sv ====
`timescale 1ns/1ps

module i2c_master_top import i2c_master_pkg::*; (
	input  logic        i_clock,
	input  logic        i_rst_n,
	input  logic        i_req,
	input  logic        i_we,
	input  logic [1:0]  i_addr,
	input  logic [31:0] i_wdata,
	output logic [31:0] o_rdata,
	output logic        o_ack,
	output logic        o_scl,
	output logic        o_sda_oe,
	output logic        o_sda_out,
	input  logic        i_sda_in
);
	logic        cmd_push, cmd_pop, cmd_empty, cmd_full;
	logic [31:0] cmd_word_in, cmd_word_out;
	logic        rx_push, rx_pop, rx_empty, rx_full;
	logic [7:0]  rx_data_in, rx_data_out;
	logic        bit_req, bit_ack, bit_nack, busy, nack;
	bit_op_e     bit_op;
	logic [7:0]  tx_byte, rx_byte;

	sync_fifo #(.WIDTH(32)) cmd_fifo_inst (
		.i_clock(i_clock), .i_rst_n(i_rst_n),
		.i_wr_en(cmd_push), .i_wr_data(cmd_word_in), .i_rd_en(cmd_pop),
		.o_rd_data(cmd_word_out), .o_empty(cmd_empty), .o_full(cmd_full)
	);

	sync_fifo #(.WIDTH(8)) rx_fifo_inst (
		.i_clock(i_clock), .i_rst_n(i_rst_n),
		.i_wr_en(rx_push), .i_wr_data(rx_data_in), .i_rd_en(rx_pop),
		.o_rd_data(rx_data_out), .o_empty(rx_empty), .o_full(rx_full)
	);

	i2c_txn_sequencer i2c_txn_sequencer_inst (
		.i_clock(i_clock), .i_rst_n(i_rst_n),
		.i_cmd_empty(cmd_empty), .i_cmd_word(cmd_word_out), .i_rx_full(rx_full),
		.i_bit_ack(bit_ack), .i_rx_byte(rx_byte), .i_bit_nack(bit_nack),
		.o_cmd_pop(cmd_pop), .o_rx_push(rx_push), .o_rx_data(rx_data_in),
		.o_bit_req(bit_req), .o_bit_op(bit_op), .o_tx_byte(tx_byte),
		.o_busy(busy), .o_nack(nack)
	);

	i2c_bit_engine i2c_bit_engine_inst (
		.i_clock(i_clock), .i_rst_n(i_rst_n),
		.i_bit_req(bit_req), .i_bit_op(bit_op), .i_tx_byte(tx_byte), .i_sda_in(i_sda_in),
		.o_bit_ack(bit_ack), .o_rx_byte(rx_byte), .o_bit_nack(bit_nack),
		.o_scl(o_scl), .o_sda_oe(o_sda_oe), .o_sda_out(o_sda_out)
	);

	i2c_host_regs i2c_host_regs_inst (
		.i_clock(i_clock), .i_rst_n(i_rst_n),
		.i_req(i_req), .i_we(i_we), .i_addr(i_addr), .i_wdata(i_wdata),
		.i_cmd_full(cmd_full), .i_cmd_empty(cmd_empty),
		.i_rx_full(rx_full), .i_rx_empty(rx_empty), .i_rx_data(rx_data_out),
		.i_busy(busy), .i_nack(nack),
		.o_rdata(o_rdata), .o_ack(o_ack),
		.o_cmd_push(cmd_push), .o_cmd_word(cmd_word_in), .o_rx_pop(rx_pop)
	);

endmodule

// ==== design/i2c_txn_sequencer.sv ====
`timescale 1ns/1ps

module i2c_txn_sequencer import i2c_master_pkg::*; (
	input  logic        i_clock,
	input  logic        i_rst_n,
	input  logic        i_cmd_empty,
	input  logic [31:0] i_cmd_word,
	input  logic        i_rx_full,
	input  logic        i_bit_ack,
	input  logic [7:0]  i_rx_byte,
	input  logic        i_bit_nack,
	output logic        o_cmd_pop,
	output logic        o_rx_push,
	output logic [7:0]  o_rx_data,
	output logic        o_bit_req,
	output bit_op_e     o_bit_op,
	output logic [7:0]  o_tx_byte,
	output logic        o_busy,
	output logic        o_nack
);
	seq_state_e state;
	i2c_cmd_e   cmd_q;
	logic [6:0] dev_addr;
	logic [7:0] reg_idx;
	logic [7:0] payload;
	logic [7:0] remain;	// Bytes left after the current one

	wire i2c_cmd_e cmd_code = i2c_cmd_e'(i_cmd_word[1:0]);
	wire step_done = o_bit_req && i_bit_ack;
	wire bus_step = (state != SEQ_IDLE) && (state != SEQ_PUSH);

	// Queued commands count as busy too
	assign o_busy = (state != SEQ_IDLE) || !i_cmd_empty;

	always_comb begin
		o_bit_op = OP_WRITE_BYTE;
		o_tx_byte = 8'h00;
		case (state)
			SEQ_START, SEQ_RESTART: o_bit_op = OP_START;
			SEQ_STOP:   o_bit_op = OP_STOP;
			SEQ_ADDR_W: o_tx_byte = {dev_addr, 1'b0};
			SEQ_REG:    o_tx_byte = reg_idx;
			SEQ_DATA:   o_tx_byte = payload;
			SEQ_ADDR_R: o_tx_byte = {dev_addr, 1'b1};
			SEQ_READ:   o_bit_op = (remain == 8'd0) ? OP_READ_NACK : OP_READ_ACK;
			default: ;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state <= SEQ_IDLE;
			o_cmd_pop <= 1'b0;
			o_rx_push <= 1'b0;
			o_bit_req <= 1'b0;
			o_nack <= 1'b0;
		end else begin
			o_cmd_pop <= 1'b0;
			o_rx_push <= 1'b0;
			if (bus_step) begin
				if (!o_bit_req && !i_bit_ack)
					o_bit_req <= 1'b1;
				else if (step_done)
					o_bit_req <= 1'b0;
			end
			case (state)
				SEQ_IDLE: begin
					if (!i_cmd_empty && !o_cmd_pop) begin
						o_cmd_pop <= 1'b1;
						o_nack <= 1'b0;
						cmd_q <= cmd_code;
						dev_addr <= i_cmd_word[14:8];
						reg_idx <= i_cmd_word[23:16];
						payload <= i_cmd_word[31:24];
						remain <= (i_cmd_word[31:24] == 8'd0) ? 8'd0 : i_cmd_word[31:24] - 8'd1;
						if (cmd_code == CMD_READ || cmd_code == CMD_WRITE)
							state <= SEQ_START;
					end
				end
				SEQ_START:   if (step_done) state <= SEQ_ADDR_W;
				SEQ_RESTART: if (step_done) state <= SEQ_ADDR_R;
				SEQ_ADDR_W, SEQ_REG, SEQ_DATA, SEQ_ADDR_R: begin
					if (step_done) begin
						if (i_bit_nack) begin
							o_nack <= 1'b1;
							state <= SEQ_STOP;
						end else if (state == SEQ_ADDR_W)
							state <= SEQ_REG;
						else if (state == SEQ_REG)
							state <= (cmd_q == CMD_READ) ? SEQ_RESTART : SEQ_DATA;
						else if (state == SEQ_ADDR_R)
							state <= SEQ_READ;
						else
							state <= SEQ_STOP;
					end
				end
				SEQ_READ: begin
					if (step_done) begin
						o_rx_data <= i_rx_byte;
						state <= SEQ_PUSH;
					end
				end
				SEQ_PUSH: begin
					if (!i_rx_full) begin	// Stall until there is room
						o_rx_push <= 1'b1;
						remain <= remain - 8'd1;
						state <= (remain == 8'd0) ? SEQ_STOP : SEQ_READ;
					end
				end
				default: if (step_done) state <= SEQ_IDLE;
			endcase
		end
	end

endmodule

// ==== design/sync_fifo.sv ====
`timescale 1ns/1ps
`include "i2c_master_defines.svh"

module sync_fifo #(
	parameter int WIDTH = 8
) (
	input  logic             i_clock,
	input  logic             i_rst_n,
	input  logic             i_wr_en,
	input  logic [WIDTH-1:0] i_wr_data,
	input  logic             i_rd_en,
	output logic [WIDTH-1:0] o_rd_data,
	output logic             o_empty,
	output logic             o_full
);
	localparam int DEPTH = `I2C_FIFO_DEPTH;
	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [AW:0]      count;

	wire do_wr = i_wr_en && !o_full;
	wire do_rd = i_rd_en && !o_empty;

	assign o_empty = (count == '0);
	assign o_full = (count == (AW+1)'(DEPTH));
	assign o_rd_data = mem[rd_ptr];	// Head shows without a read

	always_ff @(posedge i_clock) begin
		if (do_wr)
			mem[wr_ptr] <= i_wr_data;
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + (AW+1)'(do_wr) - (AW+1)'(do_rd);
		end
	end

endmodule

// ==== dv/i2c_target_model.sv ====
`timescale 1ns/1ps

module i2c_target_model #(
	parameter logic [6:0] DEV_ADDR = 7'h50
) (
	input  logic i_clock,
	input  logic i_rst_n,
	input  logic i_scl,
	input  logic i_sda,
	output logic o_sda_low
);
	typedef enum logic [2:0] {
		T_IGNORE,
		T_ADDR,
		T_REG,
		T_WRITE,
		T_READ
	} phase_e;

	logic [7:0] mem [256];
	logic [7:0] ptr;
	logic [7:0] shift;
	logic [7:0] tx;
	logic [3:0] bit_cnt;	// 8 after a full byte, 9 in the ack slot
	logic       scl_q;
	logic       sda_q;
	logic       send;
	phase_e     phase;

	wire scl_rise = i_scl && !scl_q;
	wire scl_fall = !i_scl && scl_q;
	wire start_seen = i_scl && scl_q && sda_q && !i_sda;
	wire stop_seen = i_scl && scl_q && !sda_q && i_sda;

	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = 8'(i) ^ 8'h5a;
	end

	always @(posedge i_clock) begin
		scl_q <= i_scl;
		sda_q <= i_sda;
		if (!i_rst_n) begin
			phase <= T_IGNORE;
			bit_cnt <= 4'd0;
			send <= 1'b0;
			o_sda_low <= 1'b0;
			scl_q <= 1'b1;
			sda_q <= 1'b1;
		end else if (start_seen) begin
			phase <= T_ADDR;
			bit_cnt <= 4'd0;
			o_sda_low <= 1'b0;
		end else if (stop_seen) begin
			phase <= T_IGNORE;
			o_sda_low <= 1'b0;
		end else if (scl_rise) begin
			if (bit_cnt == 4'd8)
				send <= !i_sda;	// Low in the ack slot asks for another byte
			else
				shift <= {shift[6:0], i_sda};
			bit_cnt <= bit_cnt + 4'd1;
		end else if (scl_fall) begin
			if (bit_cnt == 4'd8) begin
				o_sda_low <= 1'b0;
				case (phase)
					T_ADDR: begin
						if (shift[7:1] == DEV_ADDR) begin
							o_sda_low <= 1'b1;
							phase <= shift[0] ? T_READ : T_REG;
						end else
							phase <= T_IGNORE;
					end
					T_REG: begin
						ptr <= shift;
						o_sda_low <= 1'b1;
						phase <= T_WRITE;
					end
					T_WRITE: begin
						mem[ptr] <= shift;
						ptr <= ptr + 8'd1;
						o_sda_low <= 1'b1;
					end
					default: ;
				endcase
			end else if (bit_cnt == 4'd9) begin
				bit_cnt <= 4'd0;
				o_sda_low <= 1'b0;
				if (phase == T_READ && send) begin
					tx <= mem[ptr];
					ptr <= ptr + 8'd1;
					o_sda_low <= !mem[ptr][7];	// MSB goes out right away
				end
			end else if (phase == T_READ && bit_cnt != 4'd0)
				o_sda_low <= !tx[3'(4'd7 - bit_cnt)];
		end
	end

endmodule

// ==== dv/tb_i2c_master.sv ====
`timescale 1ns/1ps
`include "i2c_master_defines.svh"

module tb_i2c_master;
	localparam int unsigned TIMEOUT = 20000;
	localparam logic [6:0] TARGET_ADDR = 7'h50;
	localparam logic [6:0] ABSENT_ADDR = 7'h21;
	localparam logic [1:0] CODE_READ = 2'd1;
	localparam logic [1:0] CODE_WRITE = 2'd2;

	typedef enum logic [1:0] {K_STATUS, K_CMD, K_RXBYTE} kind_e;

	typedef struct packed {
		kind_e       kind;
		logic [31:0] word;
		logic [31:0] exp_val;
	} step_t;

	logic        clock = 1'b0;
	logic        rst_n;
	logic        req;
	logic        we;
	logic [1:0]  addr;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic        ack;
	logic        scl;
	logic        sda_oe;
	logic        sda_out;
	logic        target_low;
	wire         sda_line;

	step_t       steps[$];
	integer      seed = 32'hd80a_b93e;
	int unsigned cycle_count = 0;

	// Either side pulls the open-drain line low
	assign sda_line = !((sda_oe && !sda_out) || target_low);

	always #5 clock = ~clock;

	always @(posedge clock)
		cycle_count <= cycle_count + 1;

	i2c_master_top i2c_master_top_inst (
		.i_clock(clock), .i_rst_n(rst_n),
		.i_req(req), .i_we(we), .i_addr(addr), .i_wdata(wdata),
		.o_rdata(rdata), .o_ack(ack),
		.o_scl(scl), .o_sda_oe(sda_oe), .o_sda_out(sda_out), .i_sda_in(sda_line)
	);

	i2c_target_model #(.DEV_ADDR(TARGET_ADDR)) i2c_target_model_inst (
		.i_clock(clock), .i_rst_n(rst_n),
		.i_scl(scl), .i_sda(sda_line), .o_sda_low(target_low)
	);

	function automatic logic [31:0] make_cmd(input logic [1:0] code, input logic [6:0] dev,
			input logic [7:0] idx, input logic [7:0] data);
		return {data, idx, 1'b0, dev, 6'b0, code};
	endfunction

	function automatic logic [7:0] preset_value(input logic [7:0] idx);
		return idx ^ 8'h5a;
	endfunction

	task automatic stop_on_failure(input string what);
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_status(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_on_failure($sformatf("ERROR status: got 0x%08h, expected 0x%08h", got, exp));
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			stop_on_failure($sformatf("ERROR rx_data: got 0x%02h, expected 0x%02h", got, exp));
	endtask

	task automatic check_line(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_on_failure($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic host_access(input logic is_write, input logic [1:0] reg_addr,
			input logic [31:0] data, output logic [31:0] result);
		int unsigned start;
		start = cycle_count;
		req = 1'b1;
		we = is_write;
		addr = reg_addr;
		wdata = data;
		while (ack !== 1'b1) begin
			next_cycle();
			if (cycle_count - start > TIMEOUT)
				stop_on_failure("Timeout: host ack never rose");
		end
		result = rdata;
		req = 1'b0;
		start = cycle_count;
		while (ack !== 1'b0) begin
			next_cycle();
			if (cycle_count - start > TIMEOUT)
				stop_on_failure("Timeout: host ack never fell");
		end
	endtask

	// Polls the status word until busy clears
	task automatic wait_idle(output logic [31:0] status);
		int unsigned start;
		start = cycle_count;
		host_access(1'b0, `I2C_REG_CTRL, 32'h0, status);
		while (status[4]) begin
			if (cycle_count - start > TIMEOUT)
				stop_on_failure("Timeout: the master stayed busy");
			next_cycle();
			host_access(1'b0, `I2C_REG_CTRL, 32'h0, status);
		end
	endtask

	task automatic add_step(input kind_e kind, input logic [31:0] word, input logic [31:0] exp_val);
		step_t s;
		s.kind = kind;
		s.word = word;
		s.exp_val = exp_val;
		steps.push_back(s);
	endtask

	task automatic build_table();
		logic [7:0] written [5];
		add_step(K_STATUS, 32'h0, 32'h0000_000a);
		add_step(K_CMD, make_cmd(CODE_WRITE, TARGET_ADDR, 8'h10, 8'h3c), 32'h0);
		add_step(K_CMD, make_cmd(CODE_READ, TARGET_ADDR, 8'h10, 8'd1), 32'h0);
		add_step(K_RXBYTE, 32'h0, 32'h0000_003c);
		add_step(K_STATUS, 32'h0, 32'h0000_000a);
		// Burst from the preset memory
		add_step(K_CMD, make_cmd(CODE_READ, TARGET_ADDR, 8'h20, 8'd4), 32'h0);
		for (int i = 0; i < 4; i++)
			add_step(K_RXBYTE, 32'h0, {24'h0, preset_value(8'h20 + 8'(i))});
		add_step(K_STATUS, 32'h0, 32'h0000_000a);
		// No device answers here
		add_step(K_CMD, make_cmd(CODE_READ, ABSENT_ADDR, 8'h00, 8'd2), 32'h0);
		add_step(K_STATUS, 32'h0, 32'h0000_002a);
		add_step(K_CMD, make_cmd(CODE_READ, TARGET_ADDR, 8'h10, 8'd0), 32'h0);	// Count 0 is one byte
		add_step(K_RXBYTE, 32'h0, 32'h0000_003c);
		add_step(K_STATUS, 32'h0, 32'h0000_000a);
		for (int i = 0; i < 5; i++) begin
			written[i] = 8'($random(seed));
			if (written[i] == preset_value(8'h40 + 8'(i)))
				written[i] = ~written[i];
			add_step(K_CMD, make_cmd(CODE_WRITE, TARGET_ADDR, 8'h40 + 8'(i), written[i]), 32'h0);
		end
		add_step(K_CMD, make_cmd(CODE_READ, TARGET_ADDR, 8'h40, 8'd5), 32'h0);
		for (int i = 0; i < 5; i++)
			add_step(K_RXBYTE, 32'h0, {24'h0, written[i]});
		add_step(K_STATUS, 32'h0, 32'h0000_000a);
	endtask

	task automatic apply_step(input step_t s);
		logic [31:0] result;
		case (s.kind)
			K_CMD: host_access(1'b1, `I2C_REG_CTRL, s.word, result);
			K_STATUS: begin
				wait_idle(result);
				check_status(result, s.exp_val);
				check_line("scl", scl, 1'b1);	// Bus idles high
				check_line("sda", sda_line, 1'b1);
				check_line("sda_oe", sda_oe, 1'b0);
			end
			default: begin
				wait_idle(result);
				host_access(1'b0, `I2C_REG_RXDATA, 32'h0, result);
				check_byte(result[7:0], s.exp_val[7:0]);
			end
		endcase
	endtask

	initial begin
		rst_n = 1'b0;
		req = 1'b0;
		we = 1'b0;
		addr = 2'd0;
		wdata = 32'h0;
		build_table();
		repeat (8) @(posedge clock);
		#1;
		rst_n = 1'b1;
		next_cycle();
		foreach (steps[i])
			apply_step(steps[i]);
		$display("Done: no errors");
		$finish;
	end

endmodule

// ==== i2c_master.f ====
+incdir+design
design/i2c_master_pkg.sv
design/sync_fifo.sv
design/i2c_bit_engine.sv
design/i2c_txn_sequencer.sv
design/i2c_host_regs.sv
design/i2c_master_top.sv
dv/i2c_target_model.sv
dv/tb_i2c_master.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -f sim.log && \
verilator --binary --timing --timescale 1ns/1ps --top-module tb_i2c_master \
	-f i2c_master.f -o sim_tb && \
./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Done: no errors" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
